/* src/mem_pkg.sv */
package mem_pkg;

  // memory geometry
  localparam int DATA_W    = 16;
  localparam int VBNK_BITS = 2;
  localparam int VROW_BITS = 4;
  localparam int NUM_VBNK  = 1 << VBNK_BITS;
  localparam int NUM_VROW  = 1 << VROW_BITS;
  localparam int ADDR_W    = VBNK_BITS + VROW_BITS;  // bank above row

  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [VBNK_BITS-1:0] bank_t;
  typedef logic [VROW_BITS-1:0] row_t;
  typedef logic [ADDR_W-1:0]    addr_t;

  // which bank's word the cache holds for a row
  typedef struct packed {
    logic  vld;
    bank_t bank;
  } map_entry_t;

endpackage

/* src/bank_ram.sv */
`timescale 1ns/1ns

module bank_ram #(
  parameter type payload_t = mem_pkg::word_t,
  parameter int  depth     = mem_pkg::NUM_VROW
) (
  input  logic            clk,
  input  logic            we,
  input  mem_pkg::row_t   waddr,
  input  payload_t        wdata,
  input  mem_pkg::row_t   raddr,
  output payload_t        rdata
);

  payload_t mem [depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // old word on same-address write
  end

endmodule

/* src/req_stage.sv */
`timescale 1ns/1ns

module req_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           vread,
  input  mem_pkg::addr_t vrdaddr,
  input  logic           vwrite,
  input  mem_pkg::addr_t vwraddr,
  input  mem_pkg::word_t vdin,
  output logic           ready,
  output logic           rd_en,
  output mem_pkg::bank_t rd_bank,
  output mem_pkg::row_t  rd_row,
  output logic           wr_en,
  output mem_pkg::bank_t wr_bank,
  output mem_pkg::row_t  wr_row,
  output mem_pkg::word_t wr_data,
  output logic           init_en,
  output mem_pkg::row_t  init_row
);

  logic [mem_pkg::VROW_BITS:0] init_cnt;  // msb set once the sweep is done
  logic                        sweep_busy;

  assign sweep_busy = !init_cnt[mem_pkg::VROW_BITS];
  assign init_en    = sweep_busy;
  assign init_row   = init_cnt[mem_pkg::VROW_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      init_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      if (sweep_busy) begin
        init_cnt <= init_cnt + 1'b1;
      end
      ready <= !sweep_busy;
    end
  end

  // requests only count once ready
  assign rd_en   = vread && ready;
  assign rd_bank = vrdaddr[mem_pkg::ADDR_W-1:mem_pkg::VROW_BITS];
  assign rd_row  = vrdaddr[mem_pkg::VROW_BITS-1:0];
  assign wr_en   = vwrite && ready;
  assign wr_bank = vwraddr[mem_pkg::ADDR_W-1:mem_pkg::VROW_BITS];
  assign wr_row  = vwraddr[mem_pkg::VROW_BITS-1:0];
  assign wr_data = vdin;

  a_no_req_in_sweep: assert property (@(posedge clk) disable iff (rst)
    !(init_en && ready));

endmodule

/* src/map_cache.sv */
`timescale 1ns/1ns

module map_cache #(
  parameter int depth = mem_pkg::NUM_VROW
) (
  input  logic                clk,
  input  mem_pkg::row_t       rd_row,
  input  mem_pkg::row_t       wr_row,
  input  logic                init_en,
  input  mem_pkg::row_t       init_row,
  input  logic                cache_we,
  input  mem_pkg::row_t       cache_row,
  input  mem_pkg::map_entry_t cache_entry,
  input  mem_pkg::word_t      cache_data,
  output mem_pkg::map_entry_t rd_map,
  output mem_pkg::word_t      rd_cache,
  output mem_pkg::map_entry_t wr_map,
  output mem_pkg::word_t      wr_cache
);

  logic                ram_we;
  mem_pkg::row_t       ram_waddr;
  mem_pkg::map_entry_t ram_entry;
  mem_pkg::word_t      ram_data;
  mem_pkg::map_entry_t map_q  [2];
  mem_pkg::word_t      data_q [2];
  logic                byp_hit;
  mem_pkg::map_entry_t byp_entry;
  mem_pkg::word_t      byp_data;

  // sweep writes take priority over commits
  assign ram_we    = init_en || cache_we;
  assign ram_waddr = init_en ? init_row : cache_row;
  assign ram_entry = init_en ? '0 : cache_entry;
  assign ram_data  = init_en ? '0 : cache_data;

  // copy 0 serves the read path, copy 1 the write path
  for (genvar i = 0; i < 2; i++) begin : g_copy
    bank_ram #(.payload_t(mem_pkg::map_entry_t), .depth(depth)) u_map_ram (
      .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_entry),
      .raddr((i == 0) ? rd_row : wr_row), .rdata(map_q[i])
    );
    bank_ram #(.payload_t(mem_pkg::word_t), .depth(depth)) u_data_ram (
      .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_data),
      .raddr((i == 0) ? rd_row : wr_row), .rdata(data_q[i])
    );
  end

  // same-edge commit is not in the ram read yet
  always_ff @(posedge clk) begin
    byp_hit   <= ram_we && (ram_waddr == wr_row);
    byp_entry <= ram_entry;
    byp_data  <= ram_data;
  end

  assign rd_map   = map_q[0];
  assign rd_cache = data_q[0];
  assign wr_map   = byp_hit ? byp_entry : map_q[1];
  assign wr_cache = byp_hit ? byp_data : data_q[1];

endmodule

/* src/write_commit.sv */
`timescale 1ns/1ns

module write_commit (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  mem_pkg::bank_t      wr_bank,
  input  mem_pkg::row_t       wr_row,
  input  mem_pkg::word_t      wr_data,
  input  mem_pkg::map_entry_t wr_map,
  input  mem_pkg::word_t      wr_cache,
  input  logic                rd_en,
  input  mem_pkg::bank_t      rd_bank,
  output logic                cache_we,
  output mem_pkg::row_t       cache_row,
  output mem_pkg::map_entry_t cache_entry,
  output mem_pkg::word_t      cache_data,
  output logic                piv_we,
  output mem_pkg::bank_t      piv_bank,
  output mem_pkg::row_t       piv_row,
  output mem_pkg::word_t      piv_data
);

  logic           wr_en_q;
  mem_pkg::bank_t wr_bank_q;
  mem_pkg::row_t  wr_row_q;
  mem_pkg::word_t wr_data_q;
  logic           conflict;
  logic           old_same;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= wr_en;
    end
    wr_bank_q <= wr_bank;
    wr_row_q  <= wr_row;
    wr_data_q <= wr_data;
  end

  assign conflict = wr_en_q && rd_en && (rd_bank == wr_bank_q);  // pivot bank busy reading
  assign old_same = wr_map.vld && (wr_map.bank == wr_bank_q);

  always_comb begin
    cache_we         = wr_en_q && (conflict || old_same);
    cache_row        = wr_row_q;
    cache_entry.vld  = conflict;  // clear when no conflict
    cache_entry.bank = wr_bank_q;
    cache_data       = wr_data_q;
    // new word to its bank, or evict the old cache word
    piv_we   = wr_en_q && (!conflict || (wr_map.vld && !old_same));
    piv_bank = conflict ? wr_map.bank : wr_bank_q;
    piv_row  = wr_row_q;
    piv_data = conflict ? wr_cache : wr_data_q;
  end

  a_piv_not_read_bank: assert property (@(posedge clk) disable iff (rst)
    (piv_we && rd_en) |-> (piv_bank != rd_bank));

endmodule

/* src/pivot_banks.sv */
`timescale 1ns/1ns

module pivot_banks #(
  parameter int depth = mem_pkg::NUM_VROW
) (
  input  logic           clk,
  input  logic           rd_en,
  input  mem_pkg::bank_t rd_bank,
  input  mem_pkg::row_t  rd_row,
  input  logic           piv_we,
  input  mem_pkg::bank_t piv_bank,
  input  mem_pkg::row_t  piv_row,
  input  mem_pkg::word_t piv_data,
  output mem_pkg::word_t rd_data
);

  mem_pkg::word_t bank_q [mem_pkg::NUM_VBNK];
  mem_pkg::bank_t rd_bank_q;

  for (genvar i = 0; i < mem_pkg::NUM_VBNK; i++) begin : g_bank
    logic          bank_we;
    mem_pkg::row_t bank_addr;

    // single port, so the write row wins the address
    assign bank_we   = piv_we && (piv_bank == i);
    assign bank_addr = bank_we ? piv_row : rd_row;

    bank_ram #(.payload_t(mem_pkg::word_t), .depth(depth)) u_ram (
      .clk(clk), .we(bank_we), .waddr(bank_addr), .wdata(piv_data),
      .raddr(bank_addr), .rdata(bank_q[i])
    );
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_bank_q <= rd_bank;
    end
  end

  assign rd_data = bank_q[rd_bank_q];

endmodule

/* src/read_select.sv */
`timescale 1ns/1ns

module read_select (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_en,
  input  mem_pkg::bank_t      rd_bank,
  input  mem_pkg::row_t       rd_row,
  input  mem_pkg::map_entry_t rd_map,
  input  mem_pkg::word_t      rd_cache,
  input  mem_pkg::word_t      rd_data,
  input  logic                piv_we,
  input  mem_pkg::bank_t      piv_bank,
  input  mem_pkg::row_t       piv_row,
  input  mem_pkg::word_t      piv_data,
  input  logic                cache_we,
  input  mem_pkg::row_t       cache_row,
  input  mem_pkg::map_entry_t cache_entry,
  input  mem_pkg::word_t      cache_data,
  output logic                vread_vld,
  output mem_pkg::word_t      vdout
);

  logic                rd_en_q, piv_we_q, cache_we_q;
  mem_pkg::bank_t      rd_bank_q, piv_bank_q;
  mem_pkg::row_t       rd_row_q, piv_row_q, cache_row_q;
  mem_pkg::word_t      piv_data_q, cache_data_q, sel_word;
  mem_pkg::map_entry_t cache_entry_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q    <= 1'b0;
      piv_we_q   <= 1'b0;
      cache_we_q <= 1'b0;
    end else begin
      rd_en_q    <= rd_en;
      piv_we_q   <= piv_we;
      cache_we_q <= cache_we;
    end
    rd_bank_q     <= rd_bank;
    rd_row_q      <= rd_row;
    piv_bank_q    <= piv_bank;
    piv_row_q     <= piv_row;
    piv_data_q    <= piv_data;
    cache_row_q   <= cache_row;
    cache_entry_q <= cache_entry;
    cache_data_q  <= cache_data;
  end

  always_comb begin
    if (piv_we_q && (piv_bank_q == rd_bank_q) && (piv_row_q == rd_row_q)) begin
      sel_word = piv_data_q;
    end else if (cache_we_q && (cache_row_q == rd_row_q)) begin
      // map ram still shows the old entry
      sel_word = (cache_entry_q.vld && (cache_entry_q.bank == rd_bank_q)) ? cache_data_q
                                                                          : rd_data;
    end else if (rd_map.vld && (rd_map.bank == rd_bank_q)) begin
      sel_word = rd_cache;
    end else begin
      sel_word = rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vread_vld <= 1'b0;
      vdout     <= '0;
    end else begin
      vread_vld <= rd_en_q;
      if (rd_en_q) begin
        vdout <= sel_word;
      end
    end
  end

endmodule

/* src/mpmem_top.sv */
`timescale 1ns/1ns

module mpmem_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           vread,
  input  mem_pkg::addr_t vrdaddr,
  input  logic           vwrite,
  input  mem_pkg::addr_t vwraddr,
  input  mem_pkg::word_t vdin,
  output logic           vread_vld,
  output mem_pkg::word_t vdout,
  output logic           ready
);

  localparam int depth = mem_pkg::NUM_VROW;

  logic                rd_en, wr_en, init_en, cache_we, piv_we;
  mem_pkg::bank_t      rd_bank, wr_bank, piv_bank;
  mem_pkg::row_t       rd_row, wr_row, init_row, cache_row, piv_row;
  mem_pkg::word_t      wr_data, rd_cache, wr_cache, cache_data, piv_data, rd_data;
  mem_pkg::map_entry_t rd_map, wr_map, cache_entry;

  req_stage u_req_stage (
    .clk(clk), .rst(rst), .vread(vread), .vrdaddr(vrdaddr), .vwrite(vwrite),
    .vwraddr(vwraddr), .vdin(vdin), .ready(ready), .rd_en(rd_en), .rd_bank(rd_bank),
    .rd_row(rd_row), .wr_en(wr_en), .wr_bank(wr_bank), .wr_row(wr_row),
    .wr_data(wr_data), .init_en(init_en), .init_row(init_row)
  );

  map_cache #(.depth(depth)) u_map_cache (
    .clk(clk), .rd_row(rd_row), .wr_row(wr_row), .init_en(init_en), .init_row(init_row),
    .cache_we(cache_we), .cache_row(cache_row), .cache_entry(cache_entry),
    .cache_data(cache_data), .rd_map(rd_map), .rd_cache(rd_cache), .wr_map(wr_map),
    .wr_cache(wr_cache)
  );

  write_commit u_write_commit (
    .clk(clk), .rst(rst), .wr_en(wr_en), .wr_bank(wr_bank), .wr_row(wr_row),
    .wr_data(wr_data), .wr_map(wr_map), .wr_cache(wr_cache), .rd_en(rd_en),
    .rd_bank(rd_bank), .cache_we(cache_we), .cache_row(cache_row),
    .cache_entry(cache_entry), .cache_data(cache_data), .piv_we(piv_we),
    .piv_bank(piv_bank), .piv_row(piv_row), .piv_data(piv_data)
  );

  pivot_banks #(.depth(depth)) u_pivot_banks (
    .clk(clk), .rd_en(rd_en), .rd_bank(rd_bank), .rd_row(rd_row), .piv_we(piv_we),
    .piv_bank(piv_bank), .piv_row(piv_row), .piv_data(piv_data), .rd_data(rd_data)
  );

  read_select u_read_select (
    .clk(clk), .rst(rst), .rd_en(rd_en), .rd_bank(rd_bank), .rd_row(rd_row),
    .rd_map(rd_map), .rd_cache(rd_cache), .rd_data(rd_data), .piv_we(piv_we),
    .piv_bank(piv_bank), .piv_row(piv_row), .piv_data(piv_data), .cache_we(cache_we),
    .cache_row(cache_row), .cache_entry(cache_entry), .cache_data(cache_data),
    .vread_vld(vread_vld), .vdout(vdout)
  );

endmodule

/* tests/tb_mpmem.sv */
`timescale 1ns/1ns

module tb_mpmem;

  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 20;

  logic           clk;
  logic           rst;
  logic           vread;
  mem_pkg::addr_t vrdaddr;
  logic           vwrite;
  mem_pkg::addr_t vwraddr;
  mem_pkg::word_t vdin;
  logic           vread_vld;
  mem_pkg::word_t vdout;
  logic           ready;

  logic [15:0]    lfsr;
  mem_pkg::word_t model [mem_pkg::addr_t];  // last word written per address
  mem_pkg::addr_t written [$];
  int             err_cnt;
  int             chk_cnt;
  int             test_cnt;
  int             test_err0;
  int             up_cnt;  // edges since rst was last seen high
  logic           exp_ready;

  // reads in flight with stage 1 sampled at the last edge
  logic           exp1_vld, exp1_known, exp2_vld, exp2_known;
  mem_pkg::word_t exp1_word, exp2_word;

  mpmem_top u_mpmem_top (
    .clk(clk), .rst(rst), .vread(vread), .vrdaddr(vrdaddr), .vwrite(vwrite),
    .vwraddr(vwraddr), .vdin(vdin), .vread_vld(vread_vld), .vdout(vdout), .ready(ready)
  );

  always #2 clk = ~clk;

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // reference model sees inputs and outputs as they were before the edge
  always @(posedge clk) begin
    if (rst) begin
      exp1_vld = 1'b0;
      exp2_vld = 1'b0;
      up_cnt   = 0;
      model.delete();
    end else begin
      exp_ready = (up_cnt > mem_pkg::NUM_VROW);  // sweep rows plus one register stage
      if (!exp_ready) begin
        up_cnt++;
      end
      compare("ready", 32'(ready), 32'(exp_ready));
      compare("vread_vld", 32'(vread_vld), 32'(exp2_vld));
      if (exp2_vld && exp2_known) begin
        compare("vdout", 32'(vdout), 32'(exp2_word));
      end
      exp2_vld   = exp1_vld;
      exp2_known = exp1_known;
      exp2_word  = exp1_word;
      exp1_vld   = vread && exp_ready;
      exp1_known = 1'b0;
      exp1_word  = '0;
      if (exp1_vld && model.exists(vrdaddr)) begin
        exp1_known = 1'b1;
        exp1_word  = model[vrdaddr];
      end
      if (vwrite && exp_ready) begin
        model[vwraddr] = vdin;  // after the read, same-edge write stays hidden
      end
    end
  end

  task automatic drive(input logic rd, input mem_pkg::addr_t ra, input logic wr,
                       input mem_pkg::addr_t wa, input mem_pkg::word_t d);
    @(posedge clk);
    vread   <= rd;
    vrdaddr <= ra;
    vwrite  <= wr;
    vwraddr <= wa;
    vdin    <= d;
  endtask

  task automatic hold_reset();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst    <= 1'b1;
    vread  <= 1'b0;
    vwrite <= 1'b0;
    hold_reset();
  endtask

  task automatic check_ready_rise();
    int low_cnt;
    bit seen;
    low_cnt = 0;
    seen    = 1'b0;
    for (int i = 0; i < READY_TIMEOUT && !seen; i++) begin
      // random requests that the sweep must ignore
      drive(rand_bits(1) != 0, mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W)),
            rand_bits(1) != 0, mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W)),
            mem_pkg::word_t'(rand_bits(mem_pkg::DATA_W)));
      if (ready) begin
        seen = 1'b1;
      end else begin
        low_cnt++;
      end
    end
    if (!seen) begin
      err_cnt++;
      $display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
    end else begin
      // sweep of NUM_VROW rows plus one register stage
      compare("ready_low_cycles", 32'(low_cnt), 32'(mem_pkg::NUM_VROW + 1));
    end
  endtask

  task automatic drain();
    bit idle;
    idle = 1'b0;
    drive(1'b0, '0, 1'b0, '0, '0);
    for (int i = 0; i < DRAIN_TIMEOUT && !idle; i++) begin
      @(negedge clk);
      idle = !exp1_vld && !exp2_vld;
    end
    if (!idle) begin
      err_cnt++;
      $display("reads still pending after %0d idle cycles", DRAIN_TIMEOUT);
    end
  endtask

  task automatic end_test(input string name);
    drain();
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  task automatic write_then_read(input int n);
    mem_pkg::addr_t a;
    written.delete();
    for (int i = 0; i < n; i++) begin
      a = mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W));
      written.push_back(a);
      drive(1'b0, '0, 1'b1, a, mem_pkg::word_t'(rand_bits(mem_pkg::DATA_W)));
    end
    foreach (written[i]) begin
      drive(1'b1, written[i], 1'b0, '0, '0);
    end
  endtask

  task automatic conflict_traffic();
    mem_pkg::bank_t b;
    mem_pkg::row_t  wr;
    mem_pkg::row_t  rr;
    for (int i = 0; i < 48; i++) begin
      if (i % 6 == 0) begin
        b = mem_pkg::bank_t'(rand_bits(mem_pkg::VBNK_BITS));  // held so commits meet reads
      end
      wr = mem_pkg::row_t'(rand_bits(mem_pkg::VROW_BITS));
      rr = wr ^ mem_pkg::row_t'(1 + rand_bits(3));  // never the write row
      drive(1'b1, {b, rr}, 1'b1, {b, wr}, mem_pkg::word_t'(rand_bits(mem_pkg::DATA_W)));
    end
    for (int a = 0; a < (1 << mem_pkg::ADDR_W); a++) begin
      drive(1'b1, mem_pkg::addr_t'(a), 1'b0, '0, '0);
    end
    end_test("bank_conflict");
  endtask

  task automatic back_to_back_traffic();
    mem_pkg::addr_t wa;
    mem_pkg::addr_t ra;
    mem_pkg::addr_t prev_wa;
    logic           rd;
    logic           wr;
    logic [1:0]     pick;
    prev_wa = '0;
    for (int i = 0; i < 200; i++) begin
      rd   = (rand_bits(2) != 0);
      wr   = (rand_bits(2) != 0);
      wa   = mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W));
      pick = 2'(rand_bits(2));
      case (pick)
        2'd0:    ra = prev_wa;  // previous-edge write
        2'd1:    ra = wa;       // same-edge write
        default: ra = mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W));
      endcase
      drive(rd, ra, wr, wa, mem_pkg::word_t'(rand_bits(mem_pkg::DATA_W)));
      if (wr) begin
        prev_wa = wa;
      end
    end
    end_test("back_to_back");
  endtask

  task automatic reset_and_rewrite();
    for (int i = 0; i < 8; i++) begin
      drive(1'b1, mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W)), 1'b1,
            mem_pkg::addr_t'(rand_bits(mem_pkg::ADDR_W)),
            mem_pkg::word_t'(rand_bits(mem_pkg::DATA_W)));
    end
    apply_reset();
    check_ready_rise();
    write_then_read(20);
    end_test("reset_mid_run");
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    vread      = 1'b0;
    vrdaddr    = '0;
    vwrite     = 1'b0;
    vwraddr    = '0;
    vdin       = '0;
    lfsr       = 16'd45;
    err_cnt    = 0;
    chk_cnt    = 0;
    test_cnt   = 0;
    test_err0  = 0;
    up_cnt     = 0;
    exp_ready  = 1'b0;
    exp1_vld   = 1'b0;
    exp1_known = 1'b0;
    exp1_word  = '0;
    exp2_vld   = 1'b0;
    exp2_known = 1'b0;
    exp2_word  = '0;

    hold_reset();
    check_ready_rise();
    end_test("ready_after_reset");
    write_then_read(24);
    end_test("write_read");
    conflict_traffic();
    back_to_back_traffic();
    reset_and_rewrite();
    @(negedge clk);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
src/mem_pkg.sv
src/bank_ram.sv
src/req_stage.sv
src/map_cache.sv
src/write_commit.sv
src/pivot_banks.sv
src/read_select.sv
src/mpmem_top.sv
tests/tb_mpmem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Simulation finished: FAIL"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_mpmem \
  -o tb_mpmem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mpmem > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "$fail_msg" "$log"; then
  exit 1
fi
exit 0
